/* hdl/audio_ctrl_cfg.svh */
`ifndef AUDIO_CTRL_CFG_SVH
`define AUDIO_CTRL_CFG_SVH

// eq structure
`define NUM_BANDS           4
`define GAIN_FRAC           14          // fraction bits of a gain
`define GAIN_RESET          16'h4000    // unity

// spi frame, rw bit + address + data
`define FRAME_BITS          16
`define ADDR_BITS           7
`define DATA_BITS           8

`define UNMAPPED_RD         8'h99       // read value of a hole in the map

// register map
`define ADDR_AUD_CONTROL    7'h00
`define ADDR_AUD_STATUS     7'h01       // read only
`define ADDR_EQ_SEL         7'h0e
`define ADDR_EQ_GAIN_LSB    7'h0f       // write fires the gain strobe
`define ADDR_EQ_GAIN_MSB    7'h10
`define ADDR_STATUS         7'h11       // read only, irq flag in bit 7
`define ADDR_TEST           7'h12
`define ADDR_INTERRUPT      7'h13       // read only, clear on read
`define ADDR_EQ_SCALER      7'h17

`endif

/* hdl/audio_ctrl_pkg.sv */
package audio_ctrl_pkg;

    ////////////////////////////////////////////////////////////
    // register bus
    ////////////////////////////////////////////////////////////

    typedef logic [6:0] reg_addr_t;             // 7 bit register address
    typedef logic [7:0] reg_data_t;             // one register byte

    ////////////////////////////////////////////////////////////
    // audio path
    ////////////////////////////////////////////////////////////

    // pcm sample as it enters and leaves the subsystem
    typedef logic signed [15:0] sample_t;

    // band gain in q1.14, 16'h4000 is unity
    typedef logic signed [15:0] gain_t;

    // sample times gain after the >>> 14
    // two extra bits over a sample so -1 x -1 still fits
    typedef logic signed [17:0] band_out_t;

    typedef logic [1:0] band_sel_t;             // band index

endpackage

/* hdl/reg_bus_if.sv */
interface reg_bus_if;
    import audio_ctrl_pkg::*;

    logic      rd_stb;      // one cycle, after the address bits
    logic      wr_stb;      // one cycle, after the data bits
    reg_addr_t addr;        // held until end of frame
    reg_data_t wdata;
    reg_data_t rdata;       // valid the cycle after rd_stb

    // spi side
    modport slave (output rd_stb, output wr_stb, output addr, output wdata,
                   input rdata);

    // register block side
    modport regs (input rd_stb, input wr_stb, input addr, input wdata,
                  output rdata);

endinterface

/* hdl/spi_slave.sv */
`include "audio_ctrl_cfg.svh"

module spi_slave (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        spi_clk,
    input  logic        cs_n,
    input  logic        mosi,
    output logic        miso,
    output logic        miso_oe,
    reg_bus_if.slave    bus
);
    import audio_ctrl_pkg::*;

    logic [1:0]           sclk_sync;      // two flop synchronizers
    logic [1:0]           cs_sync;
    logic [1:0]           mosi_sync;
    logic                 sclk_prev;      // for edge detect
    logic                 sclk_rise;
    logic                 sclk_fall;
    logic                 cs_act;
    logic                 sample_bit;
    logic                 addr_done;
    logic                 frame_done;
    logic [4:0]           bit_cnt;        // rising edges seen in this frame
    logic                 rw_q;           // 1 = read
    logic                 rd_load;        // rd_stb delayed, rdata now valid
    logic [`ADDR_BITS-1:0] shift_in;
    reg_data_t            shift_out;

    ////////////////////////////////////////////////////////////
    // pin sync and edge detect
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sclk_sync <= '0;
            cs_sync   <= '1;          // idle deselected
            mosi_sync <= '0;
            sclk_prev <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[0], spi_clk};
            cs_sync   <= {cs_sync[0], cs_n};
            mosi_sync <= {mosi_sync[0], mosi};
            sclk_prev <= sclk_sync[1];
        end
    end

    assign sclk_rise  = sclk_sync[1] & ~sclk_prev;
    assign sclk_fall  = ~sclk_sync[1] & sclk_prev;
    assign cs_act     = ~cs_sync[1];
    assign sample_bit = cs_act & sclk_rise;     // mode 0 samples on rise
    assign addr_done  = sample_bit && (bit_cnt == 5'(`ADDR_BITS));
    assign frame_done = sample_bit && (bit_cnt == 5'(`FRAME_BITS - 1));

    ////////////////////////////////////////////////////////////
    // frame counter and strobes
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bit_cnt    <= '0;
            rw_q       <= 1'b0;
            rd_load    <= 1'b0;
            bus.rd_stb <= 1'b0;
            bus.wr_stb <= 1'b0;
        end else begin
            rd_load    <= bus.rd_stb;
            bus.rd_stb <= addr_done & shift_in[`ADDR_BITS-1];
            bus.wr_stb <= frame_done & ~rw_q;   // never fires on a cut frame
            if (!cs_act) begin
                bit_cnt <= '0;
            end else if (sclk_rise && bit_cnt != 5'(`FRAME_BITS)) begin
                bit_cnt <= bit_cnt + 5'd1;      // stops at a full frame
            end
            if (addr_done) rw_q <= shift_in[`ADDR_BITS-1];
        end
    end

    // shift register and bus payload
    always_ff @(posedge clk) begin
        if (sample_bit) shift_in <= {shift_in[`ADDR_BITS-2:0], mosi_sync[1]};
        if (addr_done)  bus.addr <= {shift_in[`ADDR_BITS-2:0], mosi_sync[1]};
        if (frame_done) bus.wdata <= {shift_in[`DATA_BITS-2:0], mosi_sync[1]};
    end

    // read data out, msb first
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            shift_out <= '0;
        end else if (!cs_act) begin
            shift_out <= '0;
        end else if (rd_load) begin
            shift_out <= bus.rdata;             // msb up before next fall
        end else if (sclk_fall && bit_cnt > 5'(`FRAME_BITS - `DATA_BITS)) begin
            shift_out <= {shift_out[`DATA_BITS-2:0], 1'b0};
        end
    end

    assign miso    = shift_out[`DATA_BITS-1];
    assign miso_oe = cs_act;

    // one access per frame
    a_no_rd_wr: assert property (@(posedge clk) disable iff (!arst_n)
        !(bus.rd_stb && bus.wr_stb));

endmodule

/* hdl/ctrl_regs.sv */
`include "audio_ctrl_cfg.svh"

module ctrl_regs (
    input  logic                      clk,
    input  logic                      arst_n,
    reg_bus_if.regs                   bus,
    input  audio_ctrl_pkg::reg_data_t aud_status,
    input  audio_ctrl_pkg::reg_data_t irq_in,
    output audio_ctrl_pkg::reg_data_t audio_control,
    output logic                      eq_wr_stb,
    output audio_ctrl_pkg::gain_t     eq_gain,
    output audio_ctrl_pkg::band_sel_t eq_sel,
    output logic [2:0]                eq_scaler
);
    import audio_ctrl_pkg::*;

    reg_data_t eq_sel_q;
    reg_data_t gain_lsb_q;
    reg_data_t gain_msb_q;
    reg_data_t test_q;
    reg_data_t eq_scaler_q;
    reg_data_t irq_held;        // captured irq_in, cleared by read
    reg_data_t irq_prev;        // last sample of irq_in
    logic      irq_flag;
    logic      int_rd_dly;      // interrupt read seen last cycle

    ////////////////////////////////////////////////////////////
    // writable registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            audio_control <= '0;
            eq_sel_q      <= '0;
            gain_lsb_q    <= '0;
            gain_msb_q    <= '0;
            test_q        <= '0;
            eq_scaler_q   <= '0;
        end else if (bus.wr_stb) begin
            case (bus.addr)
                `ADDR_AUD_CONTROL: audio_control <= bus.wdata;
                `ADDR_EQ_SEL:      eq_sel_q      <= bus.wdata;
                `ADDR_EQ_GAIN_LSB: gain_lsb_q    <= bus.wdata;
                `ADDR_EQ_GAIN_MSB: gain_msb_q    <= bus.wdata;
                `ADDR_TEST:        test_q        <= bus.wdata;
                `ADDR_EQ_SCALER:   eq_scaler_q   <= bus.wdata;
                default: ;                      // read only or unmapped
            endcase
        end
    end

    // read mux, rdata holds between reads
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bus.rdata <= '0;
        end else if (bus.rd_stb) begin
            case (bus.addr)
                `ADDR_AUD_CONTROL: bus.rdata <= audio_control;
                `ADDR_AUD_STATUS:  bus.rdata <= aud_status;
                `ADDR_EQ_SEL:      bus.rdata <= eq_sel_q;
                `ADDR_EQ_GAIN_LSB: bus.rdata <= gain_lsb_q;
                `ADDR_EQ_GAIN_MSB: bus.rdata <= gain_msb_q;
                `ADDR_STATUS:      bus.rdata <= {irq_flag, 7'b0};
                `ADDR_TEST:        bus.rdata <= test_q;
                `ADDR_INTERRUPT:   bus.rdata <= irq_held;
                `ADDR_EQ_SCALER:   bus.rdata <= eq_scaler_q;
                default:           bus.rdata <= `UNMAPPED_RD;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // gain strobe and interrupt capture
    ////////////////////////////////////////////////////////////

    // msb must already be written when the lsb arrives
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            eq_wr_stb  <= 1'b0;
            int_rd_dly <= 1'b0;
        end else begin
            eq_wr_stb  <= bus.wr_stb && (bus.addr == `ADDR_EQ_GAIN_LSB);
            int_rd_dly <= bus.rd_stb && (bus.addr == `ADDR_INTERRUPT);
        end
    end

    // change detect against the last sample so a cleared value does not retrigger
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            irq_prev <= '0;
            irq_held <= '0;
            irq_flag <= 1'b0;
        end else begin
            irq_prev <= irq_in;
            if (irq_in != irq_prev) begin       // new change wins over clear
                irq_held <= irq_in;
                irq_flag <= 1'b1;
            end else if (int_rd_dly) begin      // rdata already took the value
                irq_held <= '0;
                irq_flag <= 1'b0;
            end
        end
    end

    assign eq_gain   = {gain_msb_q, gain_lsb_q};
    assign eq_sel    = eq_sel_q[1:0];
    assign eq_scaler = eq_scaler_q[2:0];

    a_gain_stb_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        eq_wr_stb |=> !eq_wr_stb);

endmodule

/* hdl/eq_band.sv */
`include "audio_ctrl_cfg.svh"

module eq_band #(
    parameter int band_index = 0
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      in_valid,
    input  logic                      eq_wr_stb,
    input  audio_ctrl_pkg::sample_t   sample,
    input  audio_ctrl_pkg::gain_t     eq_gain,
    input  audio_ctrl_pkg::band_sel_t eq_sel,
    output audio_ctrl_pkg::band_out_t band_out,
    output logic                      out_valid
);
    import audio_ctrl_pkg::*;

    gain_t              gain_q;
    logic signed [31:0] product;        // full q1.14 product
    logic signed [31:0] product_sh;

    // gain load and valid pipe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            gain_q    <= `GAIN_RESET;           // unity
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
            if (eq_wr_stb && eq_sel == band_sel_t'(band_index)) gain_q <= eq_gain;
        end
    end

    assign product    = sample * gain_q;
    assign product_sh = product >>> `GAIN_FRAC;   // drop fraction bits

    always_ff @(posedge clk) begin
        band_out <= product_sh[17:0];           // top bits are sign only
    end

endmodule

/* hdl/eq_mixer.sv */
`include "audio_ctrl_cfg.svh"

module eq_mixer (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      in_valid,
    input  audio_ctrl_pkg::band_out_t band_out [`NUM_BANDS],
    input  logic [2:0]                eq_scaler,
    output audio_ctrl_pkg::sample_t   mix_out,
    output logic                      out_valid
);
    import audio_ctrl_pkg::*;

    // room for the sum of every band without wrap
    localparam int acc_w = $bits(band_out_t) + $clog2(`NUM_BANDS);
    localparam logic signed [acc_w-1:0] sat_max = acc_w'(32767);
    localparam logic signed [acc_w-1:0] sat_min = acc_w'(-32768);

    logic signed [acc_w-1:0] acc;
    logic signed [acc_w-1:0] scaled;

    always_comb begin
        acc = '0;
        for (int i = 0; i < `NUM_BANDS; i++) acc = acc + band_out[i];  // sign extends
    end

    assign scaled = acc >>> eq_scaler;          // arithmetic

    // saturate to 16 bit range
    always_ff @(posedge clk) begin
        if (scaled > sat_max)      mix_out <= 16'sh7fff;
        else if (scaled < sat_min) mix_out <= 16'sh8000;
        else                       mix_out <= scaled[15:0];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) out_valid <= 1'b0;
        else         out_valid <= in_valid;
    end

    a_valid_lat: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid == $past(in_valid));

endmodule

/* hdl/audio_ctrl_top.sv */
`include "audio_ctrl_cfg.svh"

module audio_ctrl_top (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      spi_clk,
    input  logic                      cs_n,
    input  logic                      mosi,
    input  logic                      sample_valid,
    input  audio_ctrl_pkg::sample_t   sample,
    input  audio_ctrl_pkg::reg_data_t aud_status,
    input  audio_ctrl_pkg::reg_data_t irq_in,
    output logic                      miso,
    output logic                      miso_oe,
    output logic                      mix_valid,
    output audio_ctrl_pkg::sample_t   mix_out,
    output audio_ctrl_pkg::reg_data_t audio_control
);
    import audio_ctrl_pkg::*;

    logic                  eq_wr_stb;
    gain_t                 eq_gain;
    band_sel_t             eq_sel;
    logic [2:0]            eq_scaler;
    band_out_t             band_out [`NUM_BANDS];
    logic [`NUM_BANDS-1:0] band_valid;      // all bands in step

    reg_bus_if bus ();

    spi_slave u_spi (.clk, .arst_n, .spi_clk, .cs_n, .mosi, .miso, .miso_oe, .bus(bus));

    ctrl_regs u_regs (.clk, .arst_n, .bus(bus), .aud_status, .irq_in, .audio_control,
                      .eq_wr_stb, .eq_gain, .eq_sel, .eq_scaler);

    for (genvar i = 0; i < `NUM_BANDS; i++) begin : g_band
        eq_band #(.band_index(i)) u_band (.clk, .arst_n, .in_valid(sample_valid),
            .eq_wr_stb, .sample, .eq_gain, .eq_sel, .band_out(band_out[i]),
            .out_valid(band_valid[i]));
    end

    eq_mixer u_mixer (.clk, .arst_n, .in_valid(band_valid[0]), .band_out, .eq_scaler,
                      .mix_out, .out_valid(mix_valid));

endmodule

/* verif/audio_ctrl_tb.sv */
`include "audio_ctrl_cfg.svh"

module audio_ctrl_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import audio_ctrl_pkg::*;

    typedef enum logic [2:0] {op_wr, op_rd, op_irq, op_gain, op_burst} op_e;

    // a burst row holds its length in addr and a fixed sample in data
    // data of 0 asks for random samples instead
    // a gain row holds the band in addr and the q1.14 gain in data
    typedef struct packed {
        op_e          op;
        reg_addr_t    addr;
        logic [15:0]  data;
        reg_data_t    exp_val;
    } row_t;

    localparam int num_rows   = 26;
    localparam int clk_period = 4;
    localparam int frame_clks = 16 * 16 + 24;   // 16 bits of two 8 clk halves plus cs gaps
    localparam int row_clks   = 3 * frame_clks; // a gain row is three frames

    logic      clk = 1'b0;
    logic      arst_n;
    logic      spi_clk;
    logic      cs_n;
    logic      mosi;
    logic      sample_valid;
    sample_t   sample;
    reg_data_t aud_status;
    reg_data_t irq_in;
    logic      miso;
    logic      miso_oe;
    logic      mix_valid;
    sample_t   mix_out;
    reg_data_t audio_control;

    gain_t       gains [`NUM_BANDS];    // model copy of the band gains
    int          scaler;
    logic [31:0] rng = 32'd72;

    row_t stim [num_rows] = '{
        '{op_wr, `ADDR_AUD_CONTROL, 16'h00a5, 8'h00}, '{op_rd, `ADDR_AUD_CONTROL, 16'h0, 8'ha5},
        '{op_wr, `ADDR_TEST, 16'h003c, 8'h00},        '{op_rd, `ADDR_TEST, 16'h0, 8'h3c},
        '{op_wr, `ADDR_EQ_SEL, 16'h0002, 8'h00},      '{op_rd, `ADDR_EQ_SEL, 16'h0, 8'h02},
        '{op_wr, `ADDR_EQ_SCALER, 16'h0005, 8'h00},   '{op_rd, `ADDR_EQ_SCALER, 16'h0, 8'h05},
        '{op_wr, `ADDR_AUD_CONTROL, 16'h005a, 8'h00}, '{op_rd, `ADDR_AUD_STATUS, 16'h0, 8'hc3},
        '{op_rd, 7'h40, 16'h0, 8'h99},                '{op_irq, 7'h00, 16'h006e, 8'h00},
        '{op_rd, `ADDR_STATUS, 16'h0, 8'h80},         '{op_rd, `ADDR_INTERRUPT, 16'h0, 8'h6e},
        '{op_rd, `ADDR_STATUS, 16'h0, 8'h00},         '{op_wr, `ADDR_EQ_SCALER, 16'h0000, 8'h00},
        '{op_burst, 7'd24, 16'h0000, 8'h00},          '{op_burst, 7'd3, 16'h7fff, 8'h00},
        '{op_burst, 7'd3, 16'h8000, 8'h00},           '{op_gain, 7'd0, 16'h7fff, 8'h00},
        '{op_gain, 7'd1, 16'h2000, 8'h00},            '{op_gain, 7'd2, 16'hc000, 8'h00},
        '{op_wr, `ADDR_EQ_SCALER, 16'h0001, 8'h00},   '{op_burst, 7'd24, 16'h0000, 8'h00},
        '{op_burst, 7'd2, 16'h7fff, 8'h00},           '{op_burst, 7'd2, 16'h8000, 8'h00}
    };

    audio_ctrl_top uut (.clk, .arst_n, .spi_clk, .cs_n, .mosi, .sample_valid, .sample,
                        .aud_status, .irq_in, .miso, .miso_oe, .mix_valid, .mix_out,
                        .audio_control);

    always #2 clk = ~clk;                       // 4 ns period

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_reg(input string name, input reg_data_t exp, input reg_data_t act);
        if (act !== exp)
            abort_run($sformatf("CHECK FAILED %s expected 0x%02h actual 0x%02h", name, exp, act));
    endtask

    task automatic check_sample(input string name, input sample_t exp, input sample_t act);
        if (act !== exp)
            abort_run($sformatf("CHECK FAILED %s expected %0d actual %0d", name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            abort_run($sformatf("CHECK FAILED %s expected %b actual %b", name, exp, act));
    endtask

    ////////////////////////////////////////////////////////////
    // spi master and audio model
    ////////////////////////////////////////////////////////////

    task automatic wait_clks(input int n);
        repeat (n) @(posedge clk);
    endtask

    // mode 0 so mosi changes while spi_clk is low and miso is taken just before the rise
    task automatic spi_frame(input logic rd, input reg_addr_t addr, input reg_data_t wdata,
                             output reg_data_t rdata);
        logic [15:0] frame;
        frame = {rd, addr, wdata};
        rdata = '0;
        @(posedge clk);
        cs_n <= 1'b0;
        wait_clks(8);
        check_bit($sformatf("addr 0x%02h miso_oe in frame", addr), 1'b1, miso_oe);
        for (int i = 15; i >= 0; i--) begin
            mosi <= frame[i];
            wait_clks(8);
            if (i < 8) rdata = {rdata[6:0], miso};   // data half of the frame
            spi_clk <= 1'b1;
            wait_clks(8);
            spi_clk <= 1'b0;
        end
        wait_clks(8);
        cs_n <= 1'b1;
        wait_clks(8);
        check_bit($sformatf("addr 0x%02h miso_oe after frame", addr), 1'b0, miso_oe);
    endtask

    task automatic spi_write(input reg_addr_t addr, input reg_data_t data);
        reg_data_t unused;
        spi_frame(1'b0, addr, data, unused);
    endtask

    task automatic spi_read(input reg_addr_t addr, output reg_data_t data);
        spi_frame(1'b1, addr, 8'h00, data);
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // sum of sample x gain >>> 14 per band, then >>> scaler, then clip to 16 bits
    function automatic sample_t mix_model(input sample_t s);
        int acc;
        int p;
        acc = 0;
        for (int b = 0; b < `NUM_BANDS; b++) begin
            p = int'(s) * int'(gains[b]);
            acc += p >>> `GAIN_FRAC;
        end
        acc = acc >>> scaler;
        if (acc > 32767) return 16'sh7fff;
        if (acc < -32768) return 16'sh8000;
        return sample_t'(acc);
    endfunction

    // back to back samples with each result seen on the third edge after its drive edge
    task automatic run_burst(input int row, input int len, input logic [15:0] fixed);
        sample_t sent [$];
        sample_t s;
        for (int k = 0; k < len + 3; k++) begin
            @(posedge clk);
            check_bit($sformatf("row %0d mix_valid cycle %0d", row, k), k >= 3, mix_valid);
            if (k >= 3)
                check_sample($sformatf("row %0d sample %0d", row, k - 3),
                             mix_model(sent[k - 3]), mix_out);
            if (k < len) begin
                rng = xorshift(rng);
                s = (fixed == 16'h0) ? sample_t'(rng[15:0]) : sample_t'(fixed);
                sent.push_back(s);
                sample       <= s;
                sample_valid <= 1'b1;
            end else begin
                sample_valid <= 1'b0;
            end
        end
    endtask

    task automatic apply_row(input int i);
        reg_data_t rd;
        string     name;
        name = $sformatf("row %0d addr 0x%02h", i, stim[i].addr);
        case (stim[i].op)
            op_wr: begin
                spi_write(stim[i].addr, stim[i].data[7:0]);
                if (stim[i].addr == `ADDR_EQ_SCALER) scaler = int'(stim[i].data[2:0]);
                if (stim[i].addr == `ADDR_AUD_CONTROL)
                    check_reg({name, " port"}, stim[i].data[7:0], audio_control);
            end
            op_rd: begin
                spi_read(stim[i].addr, rd);
                check_reg(name, stim[i].exp_val, rd);
            end
            op_irq: begin
                irq_in <= stim[i].data[7:0];
                wait_clks(4);
            end
            op_gain: begin
                spi_write(`ADDR_EQ_SEL, reg_data_t'(stim[i].addr));
                spi_write(`ADDR_EQ_GAIN_MSB, stim[i].data[15:8]);   // msb first
                spi_write(`ADDR_EQ_GAIN_LSB, stim[i].data[7:0]);
                gains[stim[i].addr[1:0]] = stim[i].data;
            end
            default: run_burst(i, int'(stim[i].addr), stim[i].data);
        endcase
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        arst_n       = 1'b0;
        spi_clk      = 1'b0;
        cs_n         = 1'b1;
        mosi         = 1'b0;
        sample_valid = 1'b0;
        sample       = '0;
        aud_status   = 8'hc3;
        irq_in       = 8'h00;
        scaler       = 0;
        for (int b = 0; b < `NUM_BANDS; b++) gains[b] = `GAIN_RESET;
        wait_clks(3);
        arst_n <= 1'b1;
        @(posedge clk);
        check_bit("reset miso_oe", 1'b0, miso_oe);
        check_bit("reset mix_valid", 1'b0, mix_valid);
        for (int i = 0; i < num_rows; i++) apply_row(i);
        $display("Test completed successfully");
        $finish;
    end

    initial begin : watchdog
        int burst_total;
        int limit;
        burst_total = 0;
        foreach (stim[r])
            if (stim[r].op == op_burst) burst_total += int'(stim[r].addr) + 3;
        limit = (num_rows * row_clks + burst_total) * 2;      // in clk cycles
        #(limit * clk_period);
        abort_run("timeout, the stimulus table did not finish in time");
    end

endmodule

/* audio_ctrl_top.f */
+incdir+hdl
hdl/audio_ctrl_pkg.sv
hdl/reg_bus_if.sv
hdl/spi_slave.sv
hdl/ctrl_regs.sv
hdl/eq_band.sv
hdl/eq_mixer.sv
hdl/audio_ctrl_top.sv
verif/audio_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
    -f audio_ctrl_top.f --top-module audio_ctrl_tb -o sim_audio_ctrl \
  && ./obj_dir/sim_audio_ctrl | grep "Test completed successfully" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
